//--- hw/nic_rx_pkg.sv
package nic_rx_pkg;

	// Largest single DMA transfer in bytes
	localparam int MAX_CHUNK = 1024;

	// Credit counts of the four credit links
	localparam int CMD_CREDITS = 2;
	localparam int PKT_CREDITS = 4;
	localparam int STAT_CREDITS = 2;
	localparam int DMA_CREDITS = 2;

	// Buffer-size codes with bit 2 as the size extension
	localparam logic [2:0] BSIZE_2048 = 3'd0;
	localparam logic [2:0] BSIZE_1024 = 3'd1;
	localparam logic [2:0] BSIZE_512 = 3'd2;
	localparam logic [2:0] BSIZE_256 = 3'd3;
	localparam logic [2:0] BSIZE_16384 = 3'd5;
	localparam logic [2:0] BSIZE_8192 = 3'd6;
	localparam logic [2:0] BSIZE_4096 = 3'd7;

	typedef logic [2:0] buf_size_t;

	// One received frame waiting in packet memory
	typedef struct packed {
		logic [15:0] length;
		logic [15:0] local_addr;
		logic [31:0] dw2;
		logic [31:0] dw3;
	} pkt_rec_t;

	typedef struct packed {
		logic [15:0] local_addr;
	} desc_cmd_t;

	// Local address of a completed descriptor
	typedef struct packed {
		logic [15:0] local_addr;
	} rx_status_t;

endpackage

//--- hw/nic_bus_pkg.sv
package nic_bus_pkg;

	// Descriptor memory request with word 2 low and word 3 high in wdata
	typedef struct packed {
		logic        we;
		logic [15:0] addr;
		logic [63:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [63:0] rdata;
	} mem_rsp_t;

	// Outbound DMA from local memory to host
	typedef struct packed {
		logic [11:0] bytes;
		logic [15:0] local_addr;
		logic [63:0] host_addr;
	} dma_cmd_t;

	typedef struct packed {
		logic        err;
		logic [15:0] local_addr;
	} dma_done_t;

	typedef struct packed {
		logic [15:0] length;
		logic [15:0] local_addr;
	} frm_free_t;

endpackage

//--- hw/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2
) (
	input  logic     aclk,
	input  logic     aresetn,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     credit,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     pop
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_ff @(posedge aclk) begin
		if (in_valid)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
		end
	end

	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	// Credit goes back in the pop cycle
	assign credit = pop;

	// Sender must not spend more credits than the queue holds
	assert property (@(posedge aclk) disable iff (!aresetn)
		in_valid |-> (count < CNT_W'(DEPTH)) || pop)
		else $error("credit_fifo: write while full");

	assert property (@(posedge aclk) disable iff (!aresetn)
		pop |-> count != '0)
		else $error("credit_fifo: pop while empty");

endmodule

//--- hw/rx_chunk_calc.sv
`timescale 1ns/1ps

module rx_chunk_calc (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  nic_rx_pkg::buf_size_t buf_size,
	input  logic                  load_pkt,
	input  nic_rx_pkg::pkt_rec_t  pkt,
	input  logic                  load_desc,
	input  logic [63:0]           host_addr,
	input  logic                  advance,
	output logic [11:0]           chunk,
	output logic [15:0]           chunk_local,
	output logic [63:0]           chunk_host,
	output logic                  pkt_done,
	output logic                  buf_full
);

	logic [15:0] buf_bytes;
	logic [15:0] remain;
	logic [15:0] avail;
	logic [15:0] min_ra;
	logic [15:0] chunk_w;

	// 2048 down to 256, or 32768 down to 4096 with the extension bit
	assign buf_bytes = buf_size[2] ? (16'd32768 >> buf_size[1:0])
		: (16'd2048 >> buf_size[1:0]);

	assign min_ra = (remain < avail) ? remain : avail;
	assign chunk_w = (min_ra > 16'(nic_rx_pkg::MAX_CHUNK)) ? 16'(nic_rx_pkg::MAX_CHUNK) : min_ra;
	assign chunk = chunk_w[11:0];

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			remain <= '0;
			avail <= '0;
		end else begin
			if (load_pkt)
				remain <= pkt.length;
			else if (advance)
				remain <= remain - chunk_w;
			if (load_desc)
				avail <= buf_bytes;
			else if (advance)
				avail <= avail - chunk_w;
		end
	end

	// Address pointers
	always_ff @(posedge aclk) begin
		if (load_pkt)
			chunk_local <= pkt.local_addr;
		else if (advance)
			chunk_local <= chunk_local + chunk_w;
		if (load_desc)
			chunk_host <= host_addr;
		else if (advance)
			chunk_host <= chunk_host + 64'(chunk_w);
	end

	assign pkt_done = (remain == '0);
	assign buf_full = (avail == '0);

endmodule

//--- hw/rx_wback_builder.sv
`timescale 1ns/1ps

module rx_wback_builder (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 clear,
	input  logic                 add,
	input  logic [11:0]          chunk,
	input  nic_rx_pkg::pkt_rec_t pkt_words,
	input  logic                 eop,
	output logic [63:0]          wdata
);

	logic [15:0] len;
	logic        eop_q;
	logic [15:0] dw2_hi;
	logic [31:0] dw3_q;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			len <= '0;
			eop_q <= 1'b0;
		end else if (clear) begin
			len <= '0;
			eop_q <= 1'b0;
		end else begin
			if (add)
				len <= len + 16'(chunk);
			if (eop)
				eop_q <= 1'b1;
		end
	end

	// Frame processor words taken at descriptor start
	always_ff @(posedge aclk) begin
		if (clear) begin
			dw2_hi <= pkt_words.dw2[31:16];
			dw3_q <= pkt_words.dw3;
		end
	end

	// Word 3 bit 1 is EOP, bit 0 is done
	assign wdata = {dw3_q[31:2], eop_q, 1'b1, dw2_hi, len};

endmodule

//--- hw/rx_dma_issue.sv
`timescale 1ns/1ps

module rx_dma_issue (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  logic                  req,
	input  logic [11:0]           chunk,
	input  logic [15:0]           chunk_local,
	input  logic [63:0]           chunk_host,
	input  logic                  dma_credit,
	output logic                  dma_valid,
	output nic_bus_pkg::dma_cmd_t dma_cmd,
	output logic                  busy
);

	localparam int CRED_W = $clog2(nic_rx_pkg::DMA_CREDITS + 1);

	logic              pending;
	logic [CRED_W-1:0] credits;

	always_ff @(posedge aclk) begin
		if (req)
			dma_cmd <= '{bytes: chunk, local_addr: chunk_local, host_addr: chunk_host};
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			pending <= 1'b0;
			credits <= CRED_W'(nic_rx_pkg::DMA_CREDITS);
		end else begin
			if (req)
				pending <= 1'b1;
			else if (dma_valid)
				pending <= 1'b0;
			credits <= credits + CRED_W'(dma_credit) - CRED_W'(dma_valid);
		end
	end

	// Held command goes out once a credit is in hand
	assign dma_valid = pending && (credits != '0);
	assign busy = pending;

	// Sink returns no more credits than were spent
	assert property (@(posedge aclk) disable iff (!aresetn)
		credits <= CRED_W'(nic_rx_pkg::DMA_CREDITS))
		else $error("rx_dma_issue: credit count out of range");

	assert property (@(posedge aclk) disable iff (!aresetn)
		req |-> !pending)
		else $error("rx_dma_issue: request while a command is held");

endmodule

//--- hw/rx_desc_ctrl.sv
`timescale 1ns/1ps

module rx_desc_ctrl (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    cmd_valid,
	input  nic_rx_pkg::desc_cmd_t   cmd,
	output logic                    cmd_pop,
	input  logic                    pkt_valid,
	output logic                    pkt_pop,
	output logic                    mem_req_valid,
	output nic_bus_pkg::mem_req_t   mem_req,
	input  logic                    mem_rsp_valid,
	input  nic_bus_pkg::mem_rsp_t   mem_rsp,
	output logic                    load_pkt,
	output logic                    load_desc,
	output logic                    advance,
	input  logic                    pkt_done,
	input  logic                    buf_full,
	input  logic [11:0]             chunk,
	input  logic [15:0]             chunk_local,
	output logic                    wb_clear,
	output logic                    wb_add,
	output logic                    wb_eop,
	input  logic [63:0]             wb_data,
	output logic                    dma_req,
	input  logic                    dma_busy,
	input  logic                    dma_done_valid,
	input  nic_bus_pkg::dma_done_t  dma_done,
	output logic                    frm_free_valid,
	output nic_bus_pkg::frm_free_t  frm_free,
	input  logic                    stat_credit,
	output logic                    stat_valid,
	output nic_rx_pkg::rx_status_t  stat
);

	localparam int SC_W = $clog2(nic_rx_pkg::STAT_CREDITS + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_RSP,
		S_CHUNK,
		S_WAIT,
		S_NEXT,
		S_WBACK,
		S_STAT
	} state_t;

	state_t          state;
	state_t          state_next;
	logic            start;
	logic            is_null;
	// Packet loaded and partly sent
	logic            pkt_active;
	logic [SC_W-1:0] stat_cred;

	// A descriptor needs a packet waiting at the queue head
	assign start = (state == S_IDLE) && cmd_valid && pkt_valid;
	assign is_null = (mem_rsp.rdata == 64'd0);

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:
				if (start)
					state_next = S_READ;
			S_READ:
				state_next = S_RSP;
			S_RSP:
				if (mem_rsp_valid)
					state_next = is_null ? S_WBACK : S_CHUNK;
			S_CHUNK:
				if (!dma_busy)
					state_next = S_WAIT;
			S_WAIT:
				if (dma_done_valid)
					state_next = S_NEXT;
			S_NEXT:
				state_next = (pkt_done || buf_full) ? S_WBACK : S_CHUNK;
			S_WBACK:
				state_next = S_STAT;
			S_STAT:
				if (stat_valid)
					state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= S_IDLE;
			pkt_active <= 1'b0;
			stat_cred <= SC_W'(nic_rx_pkg::STAT_CREDITS);
			frm_free_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (load_pkt)
				pkt_active <= 1'b1;
			else if (pkt_pop)
				pkt_active <= 1'b0;
			stat_cred <= stat_cred + SC_W'(stat_credit) - SC_W'(stat_valid);
			frm_free_valid <= advance;
		end
	end

	// Free the chunk just completed, before the counters move
	always_ff @(posedge aclk) begin
		if (advance)
			frm_free <= '{length: 16'(chunk), local_addr: chunk_local};
	end

	assign load_pkt = start && !pkt_active;
	assign wb_clear = start;
	assign load_desc = (state == S_RSP) && mem_rsp_valid;
	assign dma_req = (state == S_CHUNK) && !dma_busy;
	assign advance = (state == S_WAIT) && dma_done_valid;
	assign wb_add = advance;
	assign wb_eop = (state == S_NEXT) && pkt_done;
	assign pkt_pop = wb_eop;

	// Descriptor read, then writeback of words 2 and 3 at offset 8
	assign mem_req_valid = (state == S_READ) || (state == S_WBACK);
	assign mem_req = '{
		we: (state == S_WBACK),
		addr: (state == S_WBACK) ? cmd.local_addr + 16'd8 : cmd.local_addr,
		wdata: wb_data
	};

	assign stat_valid = (state == S_STAT) && (stat_cred != '0);
	assign cmd_pop = stat_valid;
	assign stat = '{local_addr: cmd.local_addr};

	// Completion must match the single chunk in flight
	assert property (@(posedge aclk) disable iff (!aresetn)
		dma_done_valid |-> (state == S_WAIT) && (dma_done.local_addr == chunk_local))
		else $error("rx_desc_ctrl: completion without outstanding chunk");

endmodule

//--- hw/rx_engine_top.sv
`timescale 1ns/1ps

module rx_engine_top (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  nic_rx_pkg::buf_size_t  buf_size,
	input  logic                   cmd_valid,
	input  nic_rx_pkg::desc_cmd_t  cmd,
	output logic                   cmd_credit,
	input  logic                   pkt_valid,
	input  nic_rx_pkg::pkt_rec_t   pkt,
	output logic                   pkt_credit,
	output logic                   mem_req_valid,
	output nic_bus_pkg::mem_req_t  mem_req,
	input  logic                   mem_rsp_valid,
	input  nic_bus_pkg::mem_rsp_t  mem_rsp,
	output logic                   dma_valid,
	output nic_bus_pkg::dma_cmd_t  dma_cmd,
	input  logic                   dma_credit,
	input  logic                   dma_done_valid,
	input  nic_bus_pkg::dma_done_t dma_done,
	output logic                   frm_free_valid,
	output nic_bus_pkg::frm_free_t frm_free,
	output logic                   stat_valid,
	output nic_rx_pkg::rx_status_t stat,
	input  logic                   stat_credit
);

	logic                  cq_valid;
	nic_rx_pkg::desc_cmd_t cq_data;
	logic                  cq_pop;
	logic                  pq_valid;
	nic_rx_pkg::pkt_rec_t  pq_data;
	logic                  pq_pop;
	logic                  load_pkt;
	logic                  load_desc;
	logic                  advance;
	logic [11:0]           chunk;
	logic [15:0]           chunk_local;
	logic [63:0]           chunk_host;
	logic                  pkt_done;
	logic                  buf_full;
	logic                  wb_clear;
	logic                  wb_add;
	logic                  wb_eop;
	logic [63:0]           wb_data;
	logic                  dma_req;
	logic                  dma_busy;

	credit_fifo #(
		.payload_t(nic_rx_pkg::desc_cmd_t),
		.DEPTH(nic_rx_pkg::CMD_CREDITS)
	) u_cmd_q (
		.aclk(aclk), .aresetn(aresetn),
		.in_valid(cmd_valid), .in_data(cmd), .credit(cmd_credit),
		.out_valid(cq_valid), .out_data(cq_data), .pop(cq_pop)
	);

	credit_fifo #(
		.payload_t(nic_rx_pkg::pkt_rec_t),
		.DEPTH(nic_rx_pkg::PKT_CREDITS)
	) u_pkt_q (
		.aclk(aclk), .aresetn(aresetn),
		.in_valid(pkt_valid), .in_data(pkt), .credit(pkt_credit),
		.out_valid(pq_valid), .out_data(pq_data), .pop(pq_pop)
	);

	rx_chunk_calc u_chunk (
		.aclk(aclk), .aresetn(aresetn), .buf_size(buf_size),
		.load_pkt(load_pkt), .pkt(pq_data),
		.load_desc(load_desc), .host_addr(mem_rsp.rdata), .advance(advance),
		.chunk(chunk), .chunk_local(chunk_local), .chunk_host(chunk_host),
		.pkt_done(pkt_done), .buf_full(buf_full)
	);

	rx_wback_builder u_wback (
		.aclk(aclk), .aresetn(aresetn),
		.clear(wb_clear), .add(wb_add), .chunk(chunk),
		.pkt_words(pq_data), .eop(wb_eop), .wdata(wb_data)
	);

	rx_dma_issue u_dma (
		.aclk(aclk), .aresetn(aresetn), .req(dma_req),
		.chunk(chunk), .chunk_local(chunk_local), .chunk_host(chunk_host),
		.dma_credit(dma_credit), .dma_valid(dma_valid), .dma_cmd(dma_cmd),
		.busy(dma_busy)
	);

	rx_desc_ctrl u_ctrl (
		.aclk(aclk), .aresetn(aresetn),
		.cmd_valid(cq_valid), .cmd(cq_data), .cmd_pop(cq_pop),
		.pkt_valid(pq_valid), .pkt_pop(pq_pop),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
		.load_pkt(load_pkt), .load_desc(load_desc), .advance(advance),
		.pkt_done(pkt_done), .buf_full(buf_full),
		.chunk(chunk), .chunk_local(chunk_local),
		.wb_clear(wb_clear), .wb_add(wb_add), .wb_eop(wb_eop), .wb_data(wb_data),
		.dma_req(dma_req), .dma_busy(dma_busy),
		.dma_done_valid(dma_done_valid), .dma_done(dma_done),
		.frm_free_valid(frm_free_valid), .frm_free(frm_free),
		.stat_credit(stat_credit), .stat_valid(stat_valid), .stat(stat)
	);

endmodule

//--- tests/tb_rx_models.sv
`timescale 1ns/1ps

// Local descriptor memory with one 64-bit word per 8-byte address
module desc_mem_model (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  logic                  load_en,
	input  logic [15:0]           load_addr,
	input  logic [63:0]           load_data,
	input  logic                  mem_req_valid,
	input  nic_bus_pkg::mem_req_t mem_req,
	output logic                  mem_rsp_valid,
	output nic_bus_pkg::mem_rsp_t mem_rsp
);

	logic [63:0] words [256];
	logic        rd_pending;
	logic [7:0]  rd_index;
	int          rd_wait;

	initial begin
		mem_rsp_valid = 1'b0;
		mem_rsp = '0;
		rd_pending = 1'b0;
		rd_index = '0;
		rd_wait = 0;
		for (int i = 0; i < 256; i++)
			words[i] = 64'd0;
	end

	always @(posedge aclk) begin
		if (load_en)
			words[load_addr[10:3]] = load_data;
		if (aresetn && mem_req_valid) begin
			if (mem_req.we) begin
				words[mem_req.addr[10:3]] = mem_req.wdata;
			end else begin
				rd_pending = 1'b1;
				rd_index = mem_req.addr[10:3];
				rd_wait = $urandom_range(0, 3);
			end
		end
		#1;
		mem_rsp_valid = 1'b0;
		// Read latency of 0 to 3 extra cycles
		if (rd_pending) begin
			if (rd_wait == 0) begin
				mem_rsp_valid = 1'b1;
				mem_rsp.rdata = words[rd_index];
				rd_pending = 1'b0;
			end else begin
				rd_wait--;
			end
		end
	end

endmodule

// Outbound DMA engine with slow completions and late credit returns
module dma_engine_model (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   dma_valid,
	input  nic_bus_pkg::dma_cmd_t  dma_cmd,
	output logic                   dma_credit,
	output logic                   dma_done_valid,
	output nic_bus_pkg::dma_done_t dma_done
);

	logic [15:0] inflight [$];
	int          owed;
	int          done_wait;
	int          cred_wait;

	initial begin
		dma_credit = 1'b0;
		dma_done_valid = 1'b0;
		dma_done = '0;
		owed = 0;
		done_wait = 0;
		cred_wait = 0;
	end

	always @(posedge aclk) begin
		if (aresetn && dma_valid) begin
			if (inflight.size() == 0)
				done_wait = $urandom_range(1, 6);
			inflight.push_back(dma_cmd.local_addr);
			owed++;
		end
		#1;
		dma_done_valid = 1'b0;
		dma_credit = 1'b0;
		if (inflight.size() != 0) begin
			if (done_wait == 0) begin
				dma_done_valid = 1'b1;
				dma_done.err = 1'b0;
				dma_done.local_addr = inflight.pop_front();
				done_wait = $urandom_range(1, 6);
			end else begin
				done_wait--;
			end
		end
		// Credits trickle back independently of completions
		if (owed != 0) begin
			if (cred_wait == 0) begin
				dma_credit = 1'b1;
				owed--;
				cred_wait = $urandom_range(0, 5);
			end else begin
				cred_wait--;
			end
		end
	end

endmodule

//--- tests/tb_rx_engine.sv
`timescale 1ns/1ps

module tb_rx_engine;

	localparam int NUM_ROWS = 5;
	localparam int CYCLE_LIMIT = NUM_ROWS * 3000 + 8;
	localparam logic [31:0] SEED = 32'h7267_21c2;
	localparam logic [3:0] EV_DMA = 4'd1;
	localparam logic [3:0] EV_FREE = 4'd2;
	localparam logic [3:0] EV_WBACK = 4'd3;
	localparam logic [3:0] EV_STAT = 4'd4;

	typedef struct packed {
		logic [2:0]        bsize;
		logic [15:0]       len;
		logic [15:0]       laddr;
		logic [31:0]       dw2;
		logic [31:0]       dw3;
		logic [2:0]        ndesc;
		logic [0:3][63:0]  host;
	} row_t;

	// Size code, length, packet address, word 2, word 3, descriptor count, host addresses
	localparam row_t ROWS [NUM_ROWS] = '{
		'{3'd0, 16'd600, 16'h1000, 32'h5a5a_0000, 32'hc0de_0003, 3'd1,
			'{64'h0000_0001_2000_0000, 64'd0, 64'd0, 64'd0}},
		'{3'd7, 16'd2500, 16'h2000, 32'h1111_0000, 32'h2222_0000, 3'd1,
			'{64'h0000_0002_0000_1000, 64'd0, 64'd0, 64'd0}},
		'{3'd3, 16'd700, 16'h3000, 32'h3c3c_ffff, 32'h4b4b_0001, 3'd3,
			'{64'h0000_0003_0000_4000, 64'h0000_0003_0000_5000,
			64'h0000_0003_0000_6000, 64'd0}},
		'{3'd1, 16'd900, 16'h4000, 32'h7777_1234, 32'h8888_0002, 3'd2,
			'{64'd0, 64'h0000_0004_0000_0000, 64'd0, 64'd0}},
		'{3'd2, 16'd1100, 16'h5000, 32'h9999_0000, 32'haaaa_0003, 3'd4,
			'{64'h0000_0005_0000_0000, 64'd0, 64'h0000_0005_1000_0000,
			64'h0000_0005_2000_0000}}
	};

	logic                   aclk;
	logic                   aresetn;
	nic_rx_pkg::buf_size_t  buf_size;
	logic                   cmd_valid;
	nic_rx_pkg::desc_cmd_t  cmd;
	logic                   cmd_credit;
	logic                   pkt_valid;
	nic_rx_pkg::pkt_rec_t   pkt;
	logic                   pkt_credit;
	logic                   mem_req_valid;
	nic_bus_pkg::mem_req_t  mem_req;
	logic                   mem_rsp_valid;
	nic_bus_pkg::mem_rsp_t  mem_rsp;
	logic                   dma_valid;
	nic_bus_pkg::dma_cmd_t  dma_cmd;
	logic                   dma_credit;
	logic                   dma_done_valid;
	nic_bus_pkg::dma_done_t dma_done;
	logic                   frm_free_valid;
	nic_bus_pkg::frm_free_t frm_free;
	logic                   stat_valid;
	nic_rx_pkg::rx_status_t stat;
	logic                   stat_credit;
	logic                   load_en;
	logic [15:0]            load_addr;
	logic [63:0]            load_data;

	logic [99:0] exp_ev [$];
	logic [99:0] got_ev [$];
	int errors = 0;
	int stat_count = 0;
	int cmd_sent = 0;
	int cmd_returned = 0;
	int pkt_sent = 0;
	int pkt_returned = 0;
	int dma_spent = 0;
	int dma_returned = 0;
	int stat_owed = 0;
	int stat_wait = 0;

	rx_engine_top DUT (
		.aclk(aclk), .aresetn(aresetn), .buf_size(buf_size),
		.cmd_valid(cmd_valid), .cmd(cmd), .cmd_credit(cmd_credit),
		.pkt_valid(pkt_valid), .pkt(pkt), .pkt_credit(pkt_credit),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
		.dma_valid(dma_valid), .dma_cmd(dma_cmd), .dma_credit(dma_credit),
		.dma_done_valid(dma_done_valid), .dma_done(dma_done),
		.frm_free_valid(frm_free_valid), .frm_free(frm_free),
		.stat_valid(stat_valid), .stat(stat), .stat_credit(stat_credit)
	);

	desc_mem_model u_mem (
		.aclk(aclk), .aresetn(aresetn),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp)
	);

	dma_engine_model u_dma (
		.aclk(aclk), .aresetn(aresetn), .dma_valid(dma_valid), .dma_cmd(dma_cmd),
		.dma_credit(dma_credit), .dma_done_valid(dma_done_valid), .dma_done(dma_done)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	function automatic int buf_bytes(input logic [2:0] code);
		case (code)
			nic_rx_pkg::BSIZE_2048: return 2048;
			nic_rx_pkg::BSIZE_1024: return 1024;
			nic_rx_pkg::BSIZE_512: return 512;
			nic_rx_pkg::BSIZE_256: return 256;
			nic_rx_pkg::BSIZE_16384: return 16384;
			nic_rx_pkg::BSIZE_8192: return 8192;
			nic_rx_pkg::BSIZE_4096: return 4096;
			default: return 0;
		endcase
	endfunction

	function automatic logic [99:0] dma_event(input logic [11:0] bytes,
		input logic [15:0] laddr, input logic [63:0] haddr);
		return {EV_DMA, 4'd0, bytes, laddr, haddr};
	endfunction

	function automatic logic [99:0] free_event(input logic [15:0] len, input logic [15:0] laddr);
		return {EV_FREE, 64'd0, len, laddr};
	endfunction

	function automatic logic [99:0] wback_event(input logic [15:0] addr, input logic [63:0] data);
		return {EV_WBACK, 16'd0, addr, data};
	endfunction

	function automatic logic [99:0] status_event(input logic [15:0] addr);
		return {EV_STAT, 80'd0, addr};
	endfunction

	// Chunks of min(remaining, buffer space, 1024) per descriptor
	task automatic build_expected(input row_t row, input logic [15:0] base);
		int          remain;
		int          avail;
		int          c;
		int          dlen;
		logic [15:0] laddr;
		logic [63:0] haddr;
		logic [15:0] daddr;
		logic        eop;
		remain = int'(row.len);
		laddr = row.laddr;
		for (int i = 0; i < int'(row.ndesc); i++) begin
			daddr = base + 16'(i * 16);
			dlen = 0;
			eop = 1'b0;
			if (row.host[i] != 64'd0) begin
				avail = buf_bytes(row.bsize);
				haddr = row.host[i];
				while (remain > 0 && avail > 0) begin
					c = remain;
					if (avail < c)
						c = avail;
					if (nic_rx_pkg::MAX_CHUNK < c)
						c = nic_rx_pkg::MAX_CHUNK;
					exp_ev.push_back(dma_event(12'(c), laddr, haddr));
					exp_ev.push_back(free_event(16'(c), laddr));
					remain -= c;
					avail -= c;
					dlen += c;
					laddr += 16'(c);
					haddr += 64'(c);
				end
				eop = (remain == 0);
			end
			exp_ev.push_back(wback_event(daddr + 16'd8,
				{row.dw3[31:2], eop, 1'b1, row.dw2[31:16], 16'(dlen)}));
			exp_ev.push_back(status_event(daddr));
		end
	endtask

	task automatic next_cycle();
		@(posedge aclk);
		#1;
	endtask

	task automatic preload(input logic [15:0] addr, input logic [63:0] data);
		load_en = 1'b1;
		load_addr = addr;
		load_data = data;
		next_cycle();
		load_en = 1'b0;
	endtask

	task automatic send_pkt(input nic_rx_pkg::pkt_rec_t rec);
		while (nic_rx_pkg::PKT_CREDITS + pkt_returned - pkt_sent == 0)
			next_cycle();
		pkt_valid = 1'b1;
		pkt = rec;
		pkt_sent++;
		next_cycle();
		pkt_valid = 1'b0;
	endtask

	task automatic send_cmd(input logic [15:0] addr);
		while (nic_rx_pkg::CMD_CREDITS + cmd_returned - cmd_sent == 0)
			next_cycle();
		cmd_valid = 1'b1;
		cmd.local_addr = addr;
		cmd_sent++;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	// Observed outputs in the order they occur
	always @(posedge aclk) begin
		if (aresetn) begin
			if (dma_valid) begin
				if (nic_rx_pkg::DMA_CREDITS + dma_returned - dma_spent <= 0) begin
					$display("error at %0t: DMA command sent with no credit held", $time);
					errors++;
				end
				dma_spent++;
				got_ev.push_back(dma_event(dma_cmd.bytes, dma_cmd.local_addr, dma_cmd.host_addr));
			end
			if (dma_credit)
				dma_returned++;
			if (frm_free_valid)
				got_ev.push_back(free_event(frm_free.length, frm_free.local_addr));
			if (mem_req_valid && mem_req.we)
				got_ev.push_back(wback_event(mem_req.addr, mem_req.wdata));
			if (stat_valid) begin
				got_ev.push_back(status_event(stat.local_addr));
				stat_count++;
			end
			if (cmd_credit)
				cmd_returned++;
			if (pkt_credit)
				pkt_returned++;
		end
	end

	// Status sink holds its credits back for a random time
	always @(posedge aclk) begin
		if (aresetn && stat_valid) begin
			// A credit pulse still on the wire is not yet held by the DUT
			if (stat_owed + int'(stat_credit) >= nic_rx_pkg::STAT_CREDITS) begin
				$display("error at %0t: status sent with no credit held", $time);
				errors++;
			end
			stat_owed++;
		end
		#1;
		stat_credit = 1'b0;
		if (stat_owed != 0) begin
			if (stat_wait == 0) begin
				stat_credit = 1'b1;
				stat_owed--;
				stat_wait = $urandom_range(0, 15);
			end else begin
				stat_wait--;
			end
		end
	end

	initial begin
		int          cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int          fails;
		int          err_start;
		int          stat_target;
		logic [15:0] base;
		row_t        row;
		void'($urandom(SEED));
		fails = 0;
		aresetn = 1'b0;
		buf_size = '0;
		cmd_valid = 1'b0;
		cmd = '0;
		pkt_valid = 1'b0;
		pkt = '0;
		stat_credit = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		repeat (8) @(posedge aclk);
		#1;
		aresetn = 1'b1;
		next_cycle();
		for (int r = 0; r < NUM_ROWS; r++) begin
			row = ROWS[r];
			base = 16'h0100 + 16'(r * 64);
			err_start = errors;
			exp_ev.delete();
			got_ev.delete();
			buf_size = row.bsize;
			for (int i = 0; i < int'(row.ndesc); i++)
				preload(base + 16'(i * 16), row.host[i]);
			build_expected(row, base);
			send_pkt('{length: row.len, local_addr: row.laddr, dw2: row.dw2, dw3: row.dw3});
			stat_target = stat_count + int'(row.ndesc);
			for (int i = 0; i < int'(row.ndesc); i++)
				send_cmd(base + 16'(i * 16));
			while (stat_count < stat_target)
				next_cycle();
			if (got_ev.size() != exp_ev.size()) begin
				$display("error at %0t: test %0d expected %0d events, got %0d",
					$time, r, exp_ev.size(), got_ev.size());
				errors++;
			end
			for (int k = 0; k < exp_ev.size() && k < got_ev.size(); k++) begin
				if (got_ev[k] != exp_ev[k]) begin
					$display("error at %0t: test %0d event %0d expected %h, got %h",
						$time, r, k, exp_ev[k], got_ev[k]);
					errors++;
				end
			end
			// Every command and the packet are consumed once the last status is out
			if (cmd_returned != cmd_sent || pkt_returned != pkt_sent) begin
				$display("error at %0t: test %0d credits back %0d of %0d cmd, %0d of %0d pkt",
					$time, r, cmd_returned, cmd_sent, pkt_returned, pkt_sent);
				errors++;
			end
			if (errors != err_start)
				fails++;
			$display("test %0d: %0d descriptors, %0d events, %s", r, row.ndesc,
				exp_ev.size(), (errors == err_start) ? "ok" : "FAILED");
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			NUM_ROWS, NUM_ROWS - fails, fails, errors);
		if (fails == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- verilog.f
hw/nic_rx_pkg.sv
hw/nic_bus_pkg.sv
hw/credit_fifo.sv
hw/rx_chunk_calc.sv
hw/rx_wback_builder.sv
hw/rx_dma_issue.sv
hw/rx_desc_ctrl.sv
hw/rx_engine_top.sv
tests/tb_rx_models.sv
tests/tb_rx_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive-descriptor engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rx_engine -f verilog.f -o tb_rx_engine
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_rx_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0
